// File: dv/cu_control_input.txt
// 00 control, 01 vertex base, 02 vertex count, 03 expected emitted, 04 expected dropped
// 08-0f vertex records {in_degree, vertex_id}, 10-14 expected job ids, 18-1b ext addresses
@00
00000000_c0de0001
00000000_00001000
00000000_00000008
00000000_00000005
00000000_00000003
@08
00000003_00000100
00000000_00000101
00000005_00000102
00000000_00000103
00000001_00000104
00000002_00000105
00000000_00000106
00000007_00000107
@10
00000000_00000100
00000000_00000102
00000000_00000104
00000000_00000105
00000000_00000107
@18
00000000_0000a000
00000000_0000a040
00000000_0000a080
00000000_0000a0c0

// File: cu_control_top.f
hdl/cu_pkg.sv
hdl/cu_config_regs.sv
hdl/cu_phase_fsm.sv
hdl/cu_job_counter.sv
hdl/cu_vertex_fetch.sv
hdl/cu_read_arbiter.sv
hdl/cu_response_router.sv
hdl/cu_vertex_filter.sv
hdl/cu_control_top.sv
dv/cu_control_asserts.sv
dv/cu_control_tb.sv

// File: run.sh
#!/bin/sh
# build and run the compute unit control simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f cu_control_top.f --top-module cu_control_tb -o cu_sim
output=$(./obj_dir/cu_sim)
echo "$output"
if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
else
	exit 1
fi

// File: dv/cu_control_tb.sv
////////////////////
// compute unit control testbench
// memory responder, file driven stimulus and checks on the vertex job path
////////////////////

`timescale 1ns/1ps

module cu_control_tb;

	// data file layout
	localparam int stim_depth     = 32;
	localparam int rec_base       = 8;
	localparam int ids_base       = 16;
	localparam int ext_base       = 24;
	localparam int ext_total      = 4;
	localparam int timeout_cycles = 600;

	logic                         clock;
	logic                         rstn;
	logic                         enabled;
	logic                         vertex_job_request;
	cu_pkg::cu_config_t           cu_config;
	cu_pkg::buffer_status_t       read_buffer_status;
	cu_pkg::cu_response_t         read_response_in;
	cu_pkg::cu_command_t          ext_command_in;
	cu_pkg::cu_command_t          read_command_out;
	logic                         ext_command_grant;
	cu_pkg::cu_response_t         ext_response_out;
	cu_pkg::vertex_job_t          vertex_job_out;
	logic                         cu_done;
	cu_pkg::cu_return_t           cu_return;
	logic [cu_pkg::word_bits-1:0] cu_status;

	logic [63:0]         stim [stim_depth];
	cu_pkg::cu_command_t pending [$];
	logic [47:0]         ext_expect [$];
	int  delay_left, errors, test_errors_start, tests_passed, tests_failed;
	int  jobs_seen, vertex_cmds, ext_idx, ext_responses, alfull_age, request_mode;
	logic ext_armed, ext_on, alfull_hold, last_was_vertex;
	logic ext_grant_seen;

	cu_control_top DUT (.clock(clock), .rstn(rstn), .enabled(enabled), .cu_config(cu_config),
		.read_buffer_status(read_buffer_status), .read_response_in(read_response_in),
		.ext_command_in(ext_command_in), .read_command_out(read_command_out),
		.ext_command_grant(ext_command_grant), .ext_response_out(ext_response_out),
		.vertex_job_out(vertex_job_out), .cu_done(cu_done), .cu_return(cu_return),
		.cu_status(cu_status), .vertex_job_request(vertex_job_request));

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// external grant as the arbiter saw it at the rising edge
	always @(posedge clock)
		ext_grant_seen <= ext_command_grant;

	task automatic mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic report_error(string msg);
		$display("ERROR %s", msg);
		errors++;
	endtask

	task automatic end_test(string name);
		if (errors > test_errors_start) begin
			$display("test %s: FAIL", name);
			tests_failed++;
		end else begin
			$display("test %s: ok", name);
			tests_passed++;
		end
		test_errors_start = errors;
	endtask

	////////////////////
	// one clock cycle: observe, then drive on the falling edge
	////////////////////

	task automatic tick();
		cu_pkg::cu_command_t cmd;
		logic [47:0]         offset;
		logic [47:0]         index;
		logic [47:0]         expected;
		logic                is_ext_cmd;
		@(negedge clock);
		if (alfull_hold)
			alfull_age++;
		is_ext_cmd = read_command_out.valid &&
			(read_command_out.cu_id != cu_pkg::vertex_control_id);
		if (ext_grant_seen != is_ext_cmd)
			report_error("ext_command_grant does not match the external command issued");
		if (read_command_out.valid) begin
			pending.push_back(read_command_out);
			if (alfull_hold && alfull_age >= 2)
				report_error("read command issued while alfull was held high");
			if (read_command_out.cu_id == cu_pkg::vertex_control_id) begin
				vertex_cmds++;
				last_was_vertex = 1'b1;
				if (ext_armed)
					ext_on = 1'b1;
			end else begin
				if (!last_was_vertex)
					report_error("two external commands granted in a row");
				last_was_vertex = 1'b0;
				if (ext_idx >= ext_total) begin
					report_error("external command granted with none pending");
				end else begin
					if (read_command_out.address != stim[ext_base + ext_idx][47:0])
						mismatch("ext_command", stim[ext_base + ext_idx],
							64'(read_command_out.address));
					ext_expect.push_back(stim[ext_base + ext_idx][47:0]);
				end
				ext_idx++;
			end
		end
		if (ext_response_out.valid) begin
			ext_responses++;
			if (ext_expect.size() == 0) begin
				report_error("external response without a command");
			end else begin
				expected = ext_expect.pop_front();
				if (ext_response_out.data.raw != {16'h0, expected})
					mismatch("ext_response", {16'h0, expected}, ext_response_out.data.raw);
			end
		end
		// memory answers in order, random gap between answers
		read_response_in = '0;
		if (pending.size() != 0) begin
			if (delay_left == 0) begin
				cmd = pending.pop_front();
				read_response_in.valid = 1'b1;
				read_response_in.cu_id = cmd.cu_id;
				if (cmd.cu_id == cu_pkg::vertex_control_id) begin
					offset = cmd.address - stim[1][47:0];
					index  = offset / cu_pkg::vertex_stride;
					if (index >= 48'(stim[2][31:0]))
						report_error("vertex read outside the vertex array");
					else
						read_response_in.data.raw = stim[rec_base + int'(index)];
				end else begin
					read_response_in.data.raw = {16'h0, cmd.address};
				end
				delay_left = $urandom % 3;
			end else begin
				delay_left--;
			end
		end
		case (request_mode)
			0: vertex_job_request = 1'b1;
			1: vertex_job_request = ($urandom % 4) != 0;
			default: vertex_job_request = 1'b0;
		endcase
		// job leaves on the coming rising edge
		if (vertex_job_out.valid && vertex_job_request) begin
			if (jobs_seen >= int'(stim[3]))
				report_error("more vertex jobs than expected");
			else if (vertex_job_out.vertex_id != stim[ids_base + jobs_seen][31:0])
				mismatch("vertex_job", stim[ids_base + jobs_seen], 64'(vertex_job_out.vertex_id));
			jobs_seen++;
		end
		ext_command_in.valid = ext_on && (ext_idx < ext_total);
		ext_command_in.address = (ext_idx < ext_total) ? stim[ext_base + ext_idx][47:0] : '0;
		ext_command_in.cu_id = 8'h22;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!cu_done && n < timeout_cycles) begin
			tick();
			n++;
		end
		if (!cu_done)
			report_error("timeout waiting for cu_done");
	endtask

	task automatic check_job(string name);
		if (jobs_seen != int'(stim[3]))
			mismatch({name, "_jobs"}, stim[3], 64'(jobs_seen));
		if (cu_return.emitted != stim[3][31:0])
			mismatch({name, "_emitted"}, stim[3], 64'(cu_return.emitted));
		if (cu_return.dropped != stim[4][31:0])
			mismatch({name, "_dropped"}, stim[4], 64'(cu_return.dropped));
	endtask

	task automatic restart();
		enabled = 1'b0;
		repeat (3) tick();
		jobs_seen   = 0;
		vertex_cmds = 0;
		enabled     = 1'b1;
	endtask

	initial begin
		void'($urandom(32'h0a25fd84));
		$readmemh("dv/cu_control_input.txt", stim);
		rstn = 1'b0;
		enabled = 1'b0;
		vertex_job_request = 1'b0;
		cu_config = '0;
		read_buffer_status = '{alfull: 1'b0, empty: 1'b1};
		read_response_in = '0;
		ext_command_in = '0;
		{errors, test_errors_start, tests_passed, tests_failed} = '0;
		{jobs_seen, vertex_cmds, ext_idx, ext_responses, alfull_age, delay_left} = '0;
		request_mode = 0;
		{ext_armed, ext_on, alfull_hold} = '0;
		last_was_vertex = 1'b1;
		repeat (5) tick();
		rstn = 1'b1;
		tick();
		if (read_command_out.valid || ext_command_grant || ext_response_out.valid)
			report_error("command or response outputs high after reset");
		if (vertex_job_out.valid || cu_done)
			report_error("job valid or cu_done high after reset");
		end_test("reset_values");

		// control word alone, then a zero word that must be ignored
		enabled = 1'b1;
		cu_config = '{valid: 1'b1, control: stim[0], vertex_base: '0, vertex_count: '0};
		tick();
		cu_config = '0;
		repeat (2) tick();
		cu_config.valid = 1'b1;
		tick();
		cu_config = '0;
		repeat (3) tick();
		if (cu_status != stim[0])
			mismatch("config_nonzero_rule", stim[0], cu_status);
		end_test("config_nonzero_rule");

		request_mode = 1;
		cu_config = '{valid: 1'b1, control: '0, vertex_base: stim[1][47:0],
			vertex_count: stim[2][31:0]};
		tick();
		cu_config = '0;
		wait_done();
		check_job("full_job");
		end_test("full_job");

		restart();
		request_mode = 0;
		ext_armed = 1'b1;
		wait_done();
		if (ext_idx != ext_total)
			mismatch("ext_commands", 64'(ext_total), 64'(ext_idx));
		if (ext_responses != ext_total)
			mismatch("ext_responses", 64'(ext_total), 64'(ext_responses));
		check_job("ext_interleave");
		end_test("ext_interleave");
		ext_armed = 1'b0;
		ext_on = 1'b0;

		// consumer stalls first, then the buffer reports almost full
		restart();
		request_mode = 2;
		repeat (30) tick();
		if (vertex_cmds != cu_pkg::fetch_window)
			mismatch("request_stall", 64'(cu_pkg::fetch_window), 64'(vertex_cmds));
		request_mode = 1;
		read_buffer_status.alfull = 1'b1;
		alfull_hold = 1'b1;
		alfull_age = 0;
		repeat (8) tick();
		read_buffer_status.alfull = 1'b0;
		alfull_hold = 1'b0;
		wait_done();
		check_job("backpressure");
		end_test("backpressure");

		$display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: dv/cu_control_asserts.sv
////////////////////
// handshake assertions
// alfull back-pressure, filter queue space and done phase
////////////////////

`timescale 1ns/1ps

module cu_control_asserts (
	input logic                           clock,
	input logic                           rstn,
	input logic                           enabled,
	input cu_pkg::buffer_status_t         read_buffer_status,
	input cu_pkg::cu_command_t            read_command_out,
	input cu_pkg::cu_response_t           vertex_response,
	input logic [cu_pkg::credit_bits-1:0] queue_fill,
	input logic                           count_reached,
	input cu_pkg::phase_t                 phase,
	input logic                           cu_done
);

	// status is registered, so the command register sees it two edges later
	no_command_after_alfull: assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_status.alfull |-> ##2 !read_command_out.valid)
		else $error("read command valid after alfull");

	no_response_into_full_queue: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_response.valid && queue_fill == cu_pkg::credit_max))
		else $error("vertex response while the filter queue is full");

	// done phase entered only from a reached count, held only while enabled
	done_only_in_done_phase: assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> $past(enabled) &&
			($past(count_reached) || $past(phase) == cu_pkg::phase_done))
		else $error("cu_done without a completed job");

endmodule

bind cu_control_top cu_control_asserts control_asserts (.clock(clock), .rstn(rstn),
	.enabled(enabled), .read_buffer_status(read_buffer_status),
	.read_command_out(read_command_out), .vertex_response(vertex_response),
	.queue_fill(vertex_filter.fill), .count_reached(count_reached), .phase(phase),
	.cu_done(cu_done));

// File: hdl/cu_control_top.sv
////////////////////
// compute unit control top
// vertex job path from configuration to emitted jobs
////////////////////

`timescale 1ns/1ps

module cu_control_top (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  cu_pkg::cu_config_t           cu_config,
	input  cu_pkg::buffer_status_t       read_buffer_status,
	input  cu_pkg::cu_response_t         read_response_in,
	input  cu_pkg::cu_command_t          ext_command_in,
	output cu_pkg::cu_command_t          read_command_out,
	output logic                         ext_command_grant,
	output cu_pkg::cu_response_t         ext_response_out,
	output cu_pkg::vertex_job_t          vertex_job_out,
	output logic                         cu_done,
	output cu_pkg::cu_return_t           cu_return,
	output logic [cu_pkg::word_bits-1:0] cu_status,
	input  logic                         vertex_job_request
);

	logic [cu_pkg::addr_bits-1:0]   vertex_base;
	logic [cu_pkg::vertex_bits-1:0] vertex_count;
	logic                           cu_ready;
	logic                           fetch_enable;
	logic                           count_reached;
	cu_pkg::phase_t                 phase;
	cu_pkg::cu_command_t            fetch_command;
	logic                           fetch_grant;
	cu_pkg::cu_response_t           vertex_response;
	logic                           emit_pulse;
	logic                           drop_pulse;
	logic                           credit_return;

	////////////////////
	// control and status
	////////////////////

	cu_config_regs config_regs (.clock(clock), .rstn(rstn), .enabled(enabled),
		.cu_config(cu_config), .vertex_base(vertex_base), .vertex_count(vertex_count),
		.cu_ready(cu_ready), .cu_status(cu_status));

	cu_phase_fsm phase_fsm (.clock(clock), .rstn(rstn), .enabled(enabled), .cu_ready(cu_ready),
		.count_reached(count_reached), .fetch_enable(fetch_enable), .cu_done(cu_done),
		.phase(phase));

	cu_job_counter job_counter (.clock(clock), .rstn(rstn), .phase(phase),
		.vertex_count(vertex_count), .emit_pulse(emit_pulse), .drop_pulse(drop_pulse),
		.cu_return(cu_return), .count_reached(count_reached));

	////////////////////
	// read command and response path
	////////////////////

	cu_vertex_fetch vertex_fetch (.clock(clock), .rstn(rstn), .fetch_enable(fetch_enable),
		.vertex_base(vertex_base), .vertex_count(vertex_count), .grant(fetch_grant),
		.credit_return(credit_return), .fetch_command(fetch_command));

	cu_read_arbiter read_arbiter (.clock(clock), .rstn(rstn), .fetch_command(fetch_command),
		.ext_command_in(ext_command_in), .read_buffer_status(read_buffer_status),
		.fetch_grant(fetch_grant), .ext_command_grant(ext_command_grant),
		.read_command_out(read_command_out));

	cu_response_router response_router (.clock(clock), .rstn(rstn),
		.read_response_in(read_response_in), .vertex_response(vertex_response),
		.ext_response_out(ext_response_out));

	cu_vertex_filter vertex_filter (.clock(clock), .rstn(rstn),
		.vertex_response(vertex_response), .vertex_job_request(vertex_job_request),
		.vertex_job_out(vertex_job_out), .emit_pulse(emit_pulse), .drop_pulse(drop_pulse),
		.credit_return(credit_return));

endmodule

// File: hdl/cu_vertex_filter.sv
////////////////////
// vertex filter
// in-order queue, zero in-degree vertices are dropped
////////////////////

`timescale 1ns/1ps

module cu_vertex_filter (
	input  logic                 clock,
	input  logic                 rstn,
	input  cu_pkg::cu_response_t vertex_response,
	input  logic                 vertex_job_request,
	output cu_pkg::vertex_job_t  vertex_job_out,
	output logic                 emit_pulse,
	output logic                 drop_pulse,
	output logic                 credit_return
);

	cu_pkg::vertex_record_t            queue_mem [cu_pkg::fetch_window];
	cu_pkg::vertex_record_t            head;
	logic [cu_pkg::queue_ptr_bits-1:0] wr_ptr;
	logic [cu_pkg::queue_ptr_bits-1:0] rd_ptr;
	logic [cu_pkg::credit_bits-1:0]    fill;
	logic                              head_valid;
	logic                              emit;
	logic                              drop;

	assign head       = queue_mem[rd_ptr];
	assign head_valid = (fill != '0);
	assign drop       = head_valid && (head.in_degree == '0);
	assign emit       = head_valid && (head.in_degree != '0) && vertex_job_request;

	assign vertex_job_out = '{valid: head_valid && (head.in_degree != '0),
		vertex_id: head.vertex_id, in_degree: head.in_degree};

	always_ff @(posedge clock) begin
		if (vertex_response.valid)
			queue_mem[wr_ptr] <= vertex_response.data.vertex;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill          <= '0;
			emit_pulse    <= 1'b0;
			drop_pulse    <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			if (vertex_response.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (emit || drop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({vertex_response.valid, emit || drop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// any departure frees one fetch credit
			emit_pulse    <= emit;
			drop_pulse    <= drop;
			credit_return <= emit || drop;
		end
	end

endmodule

// File: hdl/cu_response_router.sv
////////////////////
// read response router
// vertex path tags go to the filter, the rest to the external port
////////////////////

`timescale 1ns/1ps

module cu_response_router (
	input  logic                 clock,
	input  logic                 rstn,
	input  cu_pkg::cu_response_t read_response_in,
	output cu_pkg::cu_response_t vertex_response,
	output cu_pkg::cu_response_t ext_response_out
);

	logic is_vertex;

	assign is_vertex = (read_response_in.cu_id == cu_pkg::vertex_control_id);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response  <= '0;
			ext_response_out <= '0;
		end else begin
			// payload copied to both sides, only one valid is raised
			vertex_response        <= read_response_in;
			vertex_response.valid  <= read_response_in.valid && is_vertex;
			ext_response_out       <= read_response_in;
			ext_response_out.valid <= read_response_in.valid && !is_vertex;
		end
	end

endmodule

// File: hdl/cu_read_arbiter.sv
////////////////////
// read command arbiter
// round robin over fetch and external requests, held off by alfull
////////////////////

`timescale 1ns/1ps

module cu_read_arbiter (
	input  logic                   clock,
	input  logic                   rstn,
	input  cu_pkg::cu_command_t    fetch_command,
	input  cu_pkg::cu_command_t    ext_command_in,
	input  cu_pkg::buffer_status_t read_buffer_status,
	output logic                   fetch_grant,
	output logic                   ext_command_grant,
	output cu_pkg::cu_command_t    read_command_out
);

	cu_pkg::buffer_status_t read_status_q;
	logic                   last_ext;
	logic                   fetch_req;
	logic                   ext_req;

	assign fetch_req = fetch_command.valid && !read_status_q.alfull;
	assign ext_req   = ext_command_in.valid && !read_status_q.alfull;

	// on a tie the side that lost last time wins
	always_comb begin
		fetch_grant       = fetch_req && !(ext_req && !last_ext);
		ext_command_grant = ext_req && !(fetch_req && last_ext);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_status_q    <= '{alfull: 1'b0, empty: 1'b1};
			last_ext         <= 1'b0;
			read_command_out <= '0;
		end else begin
			read_status_q <= read_buffer_status;
			if (fetch_grant)
				last_ext <= 1'b0;
			else if (ext_command_grant)
				last_ext <= 1'b1;
			read_command_out       <= ext_command_grant ? ext_command_in : fetch_command;
			read_command_out.valid <= fetch_grant || ext_command_grant;
		end
	end

endmodule

// File: hdl/cu_vertex_fetch.sv
////////////////////
// vertex fetch engine
// one read per vertex record, limited by a credit window
////////////////////

`timescale 1ns/1ps

module cu_vertex_fetch (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           fetch_enable,
	input  logic [cu_pkg::addr_bits-1:0]   vertex_base,
	input  logic [cu_pkg::vertex_bits-1:0] vertex_count,
	input  logic                           grant,
	input  logic                           credit_return,
	output cu_pkg::cu_command_t            fetch_command
);

	logic [cu_pkg::vertex_bits-1:0] issued;
	logic [cu_pkg::vertex_bits-1:0] issued_next;
	logic [cu_pkg::credit_bits-1:0] credits;
	logic [cu_pkg::credit_bits-1:0] credits_next;
	logic [cu_pkg::addr_bits-1:0]   fetch_offset;
	logic                           take;

	assign take = fetch_command.valid && grant;

	// a credit leaves with each grant and comes back when the filter frees a slot
	always_comb begin
		issued_next  = issued;
		credits_next = credits;
		if (take) begin
			issued_next  = issued + 1'b1;
			credits_next = credits_next - 1'b1;
		end
		if (credit_return)
			credits_next = credits_next + 1'b1;
	end

	assign fetch_offset = {{(cu_pkg::addr_bits - cu_pkg::vertex_bits){1'b0}}, issued_next} *
		cu_pkg::vertex_stride;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued        <= '0;
			credits       <= cu_pkg::credit_max;
			fetch_command <= '0;
		end else if (!fetch_enable) begin
			issued              <= '0;
			credits             <= cu_pkg::credit_max;
			fetch_command.valid <= 1'b0;
		end else begin
			issued  <= issued_next;
			credits <= credits_next;
			// hold until granted, then offer the next index if a credit is free
			fetch_command.valid <= (fetch_command.valid && !grant) ||
				((issued_next < vertex_count) && (credits_next != '0));
			fetch_command.address <= vertex_base + fetch_offset;
			fetch_command.cu_id   <= cu_pkg::vertex_control_id;
		end
	end

endmodule

// File: hdl/cu_job_counter.sv
////////////////////
// job counter
// emitted and dropped totals, return record and completion
////////////////////

`timescale 1ns/1ps

module cu_job_counter (
	input  logic                           clock,
	input  logic                           rstn,
	input  cu_pkg::phase_t                 phase,
	input  logic [cu_pkg::vertex_bits-1:0] vertex_count,
	input  logic                           emit_pulse,
	input  logic                           drop_pulse,
	output cu_pkg::cu_return_t             cu_return,
	output logic                           count_reached
);

	logic [cu_pkg::vertex_bits-1:0] emitted_count;
	logic [cu_pkg::vertex_bits-1:0] dropped_count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			emitted_count <= '0;
			dropped_count <= '0;
		end else if (phase == cu_pkg::phase_idle) begin
			emitted_count <= '0;
			dropped_count <= '0;
		end else begin
			if (emit_pulse)
				emitted_count <= emitted_count + 1'b1;
			if (drop_pulse)
				dropped_count <= dropped_count + 1'b1;
		end
	end

	// compared on the registered totals, so one cycle behind the last pulse
	assign count_reached = (phase == cu_pkg::phase_fetch) &&
		((emitted_count + dropped_count) == vertex_count);

	assign cu_return = '{emitted: emitted_count, dropped: dropped_count};

endmodule

// File: hdl/cu_phase_fsm.sv
////////////////////
// job phase FSM
// idle, fetch, drain and done for one vertex job
////////////////////

`timescale 1ns/1ps

module cu_phase_fsm (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  logic           cu_ready,
	input  logic           count_reached,
	output logic           fetch_enable,
	output logic           cu_done,
	output cu_pkg::phase_t phase
);

	cu_pkg::phase_t phase_next;

	always_comb begin
		phase_next = phase;
		if (!enabled) begin
			// done winds down through drain, everything else drops straight to idle
			if (phase == cu_pkg::phase_done)
				phase_next = cu_pkg::phase_drain;
			else
				phase_next = cu_pkg::phase_idle;
		end else begin
			case (phase)
				cu_pkg::phase_idle: begin
					if (cu_ready)
						phase_next = cu_pkg::phase_fetch;
				end
				cu_pkg::phase_fetch: begin
					if (count_reached)
						phase_next = cu_pkg::phase_done;
				end
				cu_pkg::phase_drain: begin
					phase_next = cu_pkg::phase_idle;
				end
				default: begin
					// done holds while the host keeps the unit enabled
					phase_next = cu_pkg::phase_done;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			phase <= cu_pkg::phase_idle;
		end else begin
			phase <= phase_next;
		end
	end

	assign fetch_enable = (phase == cu_pkg::phase_fetch);
	assign cu_done      = (phase == cu_pkg::phase_done);

endmodule

// File: hdl/cu_config_regs.sv
////////////////////
// configuration registers
// keeps the last non-zero value of each field and derives readiness
////////////////////

`timescale 1ns/1ps

module cu_config_regs (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  cu_pkg::cu_config_t             cu_config,
	output logic [cu_pkg::addr_bits-1:0]   vertex_base,
	output logic [cu_pkg::vertex_bits-1:0] vertex_count,
	output logic                           cu_ready,
	output logic [cu_pkg::word_bits-1:0]   cu_status
);

	logic [cu_pkg::word_bits-1:0] control_word;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			control_word <= '0;
			vertex_base  <= '0;
			vertex_count <= '0;
			cu_status    <= '0;
		end else begin
			// a zero field leaves the earlier value in place
			if (enabled && cu_config.valid) begin
				if (|cu_config.control)
					control_word <= cu_config.control;
				if (|cu_config.vertex_base)
					vertex_base <= cu_config.vertex_base;
				if (|cu_config.vertex_count)
					vertex_count <= cu_config.vertex_count;
			end
			cu_status <= control_word;
		end
	end

	// every required word has been written
	assign cu_ready = (|control_word) && (|vertex_base) && (|vertex_count);

endmodule

// File: hdl/cu_pkg.sv
////////////////////
// compute unit vertex path definitions
// widths, ids and the packed types shared by every block
////////////////////

package cu_pkg;

	// word and field widths
	localparam int word_bits   = 64;
	localparam int addr_bits   = 48;
	localparam int vertex_bits = 32;
	localparam int cu_id_bits  = 8;

	// tag carried by every vertex path command and response
	localparam logic [cu_id_bits-1:0] vertex_control_id = 8'h01;

	// vertices outstanding or queued at any time
	localparam int fetch_window   = 4;
	localparam int credit_bits    = $clog2(fetch_window + 1);
	localparam int queue_ptr_bits = $clog2(fetch_window);
	localparam logic [credit_bits-1:0] credit_max = credit_bits'(fetch_window);

	// bytes between two vertex records
	localparam logic [addr_bits-1:0] vertex_stride = 48'd8;

	typedef struct packed {
		logic                   valid;
		logic [word_bits-1:0]   control;
		logic [addr_bits-1:0]   vertex_base;
		logic [vertex_bits-1:0] vertex_count;
	} cu_config_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_bits-1:0]  address;
		logic [cu_id_bits-1:0] cu_id;
	} cu_command_t;

	typedef struct packed {
		logic [vertex_bits-1:0] in_degree;
		logic [vertex_bits-1:0] vertex_id;
	} vertex_record_t;

	// raw word on the external path, vertex record on the filter side
	typedef union packed {
		logic [word_bits-1:0] raw;
		vertex_record_t       vertex;
	} cu_data_u;

	typedef struct packed {
		logic                  valid;
		logic [cu_id_bits-1:0] cu_id;
		cu_data_u              data;
	} cu_response_t;

	typedef struct packed {
		logic alfull;
		logic empty;
	} buffer_status_t;

	typedef struct packed {
		logic                   valid;
		logic [vertex_bits-1:0] vertex_id;
		logic [vertex_bits-1:0] in_degree;
	} vertex_job_t;

	typedef struct packed {
		logic [vertex_bits-1:0] emitted;
		logic [vertex_bits-1:0] dropped;
	} cu_return_t;

	typedef enum logic [1:0] {
		phase_idle,
		phase_fetch,
		phase_drain,
		phase_done
	} phase_t;

endpackage
